// ==== tests/debug_input.txt ====
# name operation address data expected, all values in hex
# resume uses data for the older replayed read, pause uses data as the second address
start_pulse    start   0   0                 1
dbg_wr_10      dwr     10  0123456789abcdef  0123456789abcdef
dbg_rd_10      drd     10  0                 0123456789abcdef
dbg_wr_11      dwr     11  fedcba9876543210  fedcba9876543210
dbg_rd_11      drd     11  0                 fedcba9876543210
dbg_rd_fill    drd     40  0                 5eed0040ffffffbf
run_on         run     0   0                 1
prog_wr_a      pwa     20  a5a5a5a500000020  a5a5a5a500000020
prog_wr_b      pwb     21  5a5a5a5a00000021  5a5a5a5a00000021
prog_rd_a      pra     21  0                 5a5a5a5a00000021
prog_rd_b      prb     20  0                 a5a5a5a500000020
prog_rd_dbg    prb     10  0                 0123456789abcdef
dbg_blocked    dblk    20  deadbeefdeadbeef  a5a5a5a500000020
pause_reads    pause   20  21                5a5a5a5a00000021
dbg_rd_prog    drd     21  0                 5a5a5a5a00000021
dbg_wr_30      dwr     30  cafef00d12345678  cafef00d12345678
resume_replay  resume  0   a5a5a5a500000020  5a5a5a5a00000021
prog_rd_30     pra     30  0                 cafef00d12345678
run_off        stop    0   0                 0
dbg_rd_20      drd     20  0                 a5a5a5a500000020

// ==== src.f ====
hw/mem_pkg.sv
hw/debug_pkg.sv
hw/mem_port_if.sv
hw/run_control.sv
hw/supervisor_fsm.sv
hw/read_replay.sv
hw/debug_top.sv
tests/tb_debug_top.sv

// ==== Bender.yml ====
package:
  name: hls_debug_memory

sources:
  - hw/mem_pkg.sv
  - hw/debug_pkg.sv
  - hw/mem_port_if.sv
  - hw/run_control.sv
  - hw/supervisor_fsm.sv
  - hw/read_replay.sv
  - hw/debug_top.sv
  - target: test
    files:
      - tests/tb_debug_top.sv

// ==== tests/tb_debug_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_debug_top;

    localparam int clk_period = 8;
    localparam int mem_words = 256;
    // Debug completion cycle counted from the cycle the request is driven
    localparam int write_latency = 2;
    localparam int read_latency = 3;

    logic clk = 1'b0;
    logic reset;
    logic run_req;
    logic reset_req;
    logic finish;
    logic start;
    logic program_clk_en;
    logic program_reset;

    logic           main_enable_a;
    logic           main_enable_b;
    logic           main_write_enable_a;
    logic           main_write_enable_b;
    mem_pkg::addr_t main_address_a;
    mem_pkg::addr_t main_address_b;
    mem_pkg::data_t main_in_a;
    mem_pkg::data_t main_in_b;
    mem_pkg::size_t main_size_a;
    mem_pkg::size_t main_size_b;
    mem_pkg::data_t main_out_a;
    mem_pkg::data_t main_out_b;

    logic           memory_controller_enable_a;
    logic           memory_controller_enable_b;
    logic           memory_controller_write_enable_a;
    logic           memory_controller_write_enable_b;
    mem_pkg::addr_t memory_controller_address_a;
    mem_pkg::addr_t memory_controller_address_b;
    mem_pkg::data_t memory_controller_in_a;
    mem_pkg::data_t memory_controller_in_b;
    mem_pkg::size_t memory_controller_size_a;
    mem_pkg::size_t memory_controller_size_b;
    mem_pkg::data_t memory_controller_out_a = '0;
    mem_pkg::data_t memory_controller_out_b = '0;

    logic           dbg_rd_en;
    logic           dbg_wr_en;
    mem_pkg::addr_t dbg_addr;
    mem_pkg::data_t dbg_writedata;
    mem_pkg::data_t dbg_readdata;
    logic           dbg_waitrequest;

    mem_pkg::data_t mem [mem_words];
    mem_pkg::data_t stage_a = '0;
    mem_pkg::data_t stage_b = '0;

    int errors = 0;
    int failed_tests = 0;
    int num_tests = 0;
    bit loaded = 1'b0;

    string          names[$];
    string          ops[$];
    mem_pkg::addr_t addrs[$];
    mem_pkg::data_t datas[$];
    mem_pkg::data_t exps[$];

    always #(clk_period / 2) clk = ~clk;

    debug_top #(
        .replay_on_resume (1'b1)
    ) i_debug_top (.*);

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = {32'(i) ^ 32'h5eed_0000, ~32'(i)};
        end
    end

    // Address stage then data stage with read data held between accesses
    always @(posedge clk) begin
        if (memory_controller_enable_a) begin
            if (memory_controller_write_enable_a) begin
                mem[memory_controller_address_a[7:0]] <= memory_controller_in_a;
            end
            stage_a <= mem[memory_controller_address_a[7:0]];
        end
        if (memory_controller_enable_b) begin
            if (memory_controller_write_enable_b) begin
                mem[memory_controller_address_b[7:0]] <= memory_controller_in_b;
            end
            stage_b <= mem[memory_controller_address_b[7:0]];
        end
        memory_controller_out_a <= stage_a;
        memory_controller_out_b <= stage_b;
    end

    task automatic check_data(input string name, input mem_pkg::data_t expected,
                              input mem_pkg::data_t actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_size(input string name, input mem_pkg::size_t expected,
                              input mem_pkg::size_t actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic debug_access(input string name, input bit is_write,
                                input mem_pkg::addr_t addr, input mem_pkg::data_t data,
                                output mem_pkg::data_t rdata);
        int cycles;
        cycles = 0;
        @(negedge clk);
        dbg_addr      = addr;
        dbg_writedata = data;
        dbg_wr_en     = is_write;
        dbg_rd_en     = ~is_write;
        do begin
            @(negedge clk);
            cycles++;
        end while (dbg_waitrequest && cycles < 16);
        rdata = dbg_readdata;
        dbg_wr_en = 1'b0;
        dbg_rd_en = 1'b0;
        if (dbg_waitrequest) begin
            errors++;
            $display("%s: dbg_waitrequest never dropped", name);
        end else begin
            check_count({name, " latency"}, is_write ? write_latency : read_latency, cycles);
        end
    endtask

    // One program access on port A or B held for a single cycle
    task automatic program_access(input string name, input bit port_b, input bit we,
                                  input mem_pkg::addr_t addr, input mem_pkg::data_t data);
        @(negedge clk);
        if (port_b) begin
            main_enable_b       = 1'b1;
            main_write_enable_b = we;
            main_address_b      = addr;
            main_in_b           = data;
        end else begin
            main_enable_a       = 1'b1;
            main_write_enable_a = we;
            main_address_a      = addr;
            main_in_a           = data;
        end
        @(negedge clk);
        if (port_b) begin
            check_size({name, " size"}, main_size_b, memory_controller_size_b);
        end else begin
            check_size({name, " size"}, main_size_a, memory_controller_size_a);
        end
        main_enable_a       = 1'b0;
        main_enable_b       = 1'b0;
        main_write_enable_a = 1'b0;
        main_write_enable_b = 1'b0;
    endtask

    task automatic run_test(input int t);
        string          name;
        mem_pkg::data_t rdata;
        int             count;
        name = names[t];
        case (ops[t])
            "start": begin
                @(negedge clk);
                reset_req = 1'b1;
                repeat (3) begin
                    @(negedge clk);
                    check_bit({name, " clk_en in reset"}, 1'b1, program_clk_en);
                    check_bit({name, " program_reset"}, 1'b1, program_reset);
                end
                reset_req = 1'b0;
                run_req   = 1'b1;
                count = 0;
                repeat (6) begin
                    @(negedge clk);
                    if (start) begin
                        count++;
                    end
                end
                check_bit({name, " program_reset released"}, 1'b0, program_reset);
                check_count(name, int'(exps[t]), count);
                run_req = 1'b0;
                repeat (2) @(negedge clk);
            end
            "dwr": begin
                debug_access(name, 1'b1, addrs[t], datas[t], rdata);
                check_data(name, exps[t], mem[addrs[t][7:0]]);
            end
            "drd": begin
                debug_access(name, 1'b0, addrs[t], '0, rdata);
                check_data(name, exps[t], rdata);
            end
            "run", "stop": begin
                @(negedge clk);
                run_req = (ops[t] == "run");
                repeat (2) @(negedge clk);
                check_bit(name, exps[t][0], program_clk_en);
            end
            "pwa", "pwb": begin
                program_access(name, ops[t] == "pwb", 1'b1, addrs[t], datas[t]);
                check_data(name, exps[t], mem[addrs[t][7:0]]);
            end
            "pra", "prb": begin
                program_access(name, ops[t] == "prb", 1'b0, addrs[t], '0);
                @(negedge clk);
                check_data(name, exps[t], (ops[t] == "prb") ? main_out_b : main_out_a);
            end
            "dblk": begin
                @(negedge clk);
                dbg_addr      = addrs[t];
                dbg_writedata = datas[t];
                dbg_wr_en     = 1'b1;
                repeat (4) begin
                    @(negedge clk);
                    check_bit({name, " waitrequest"}, 1'b1, dbg_waitrequest);
                end
                dbg_wr_en = 1'b0;
                @(negedge clk);
                check_data(name, exps[t], mem[addrs[t][7:0]]);
            end
            // Two back-to-back reads on port A before the program stops
            "pause": begin
                @(negedge clk);
                main_enable_a  = 1'b1;
                main_address_a = addrs[t];
                @(negedge clk);
                main_address_a = datas[t][31:0];
                @(negedge clk);
                main_enable_a = 1'b0;
                run_req       = 1'b0;
                repeat (3) @(negedge clk);
                check_data(name, exps[t], main_out_a);
            end
            "resume": begin
                @(negedge clk);
                run_req = 1'b1;
                #1;
                check_data({name, " older"}, datas[t], main_out_a);
                @(negedge clk);
                check_data({name, " newer"}, exps[t], main_out_a);
                @(negedge clk);
                check_data({name, " live"}, memory_controller_out_a, main_out_a);
            end
            default: begin
                errors++;
                $display("%s: unknown operation %s", name, ops[t]);
            end
        endcase
    endtask

    initial begin
        int             fd;
        int             n;
        int             err_before;
        string          line;
        string          name;
        string          op;
        mem_pkg::addr_t addr;
        mem_pkg::data_t data;
        mem_pkg::data_t expected;

        reset               = 1'b1;
        run_req             = 1'b0;
        reset_req           = 1'b0;
        finish              = 1'b0;
        main_enable_a       = 1'b0;
        main_enable_b       = 1'b0;
        main_write_enable_a = 1'b0;
        main_write_enable_b = 1'b0;
        main_address_a      = '0;
        main_address_b      = '0;
        main_in_a           = '0;
        main_in_b           = '0;
        main_size_a         = 2'd3;
        main_size_b         = 2'd3;
        dbg_rd_en           = 1'b0;
        dbg_wr_en           = 1'b0;
        dbg_addr            = '0;
        dbg_writedata       = '0;

        fd = $fopen("tests/debug_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open tests/debug_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, expected);
                if (n == 5) begin
                    names.push_back(name);
                    ops.push_back(op);
                    addrs.push_back(addr);
                    datas.push_back(data);
                    exps.push_back(expected);
                end else if (n > 0 && name != "#") begin
                    errors++;
                    $display("cannot parse input line: %s", line);
                end
            end
            $fclose(fd);
        end
        num_tests = names.size();
        loaded = 1'b1;

        repeat (3) @(negedge clk);
        reset = 1'b0;

        for (int t = 0; t < num_tests; t++) begin
            err_before = errors;
            run_test(t);
            if (errors == err_before) begin
                $display("%s: ok", names[t]);
            end else begin
                failed_tests++;
                $display("%s: failed", names[t]);
            end
        end

        $display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
        if (errors == 0 && num_tests > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Allows 200 cycles for every test line
    initial begin
        wait (loaded);
        #((num_tests + 1) * 200 * clk_period);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/debug_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module debug_top #(
    parameter bit replay_on_resume = 1'b1
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           run_req,
    input  wire logic           reset_req,
    input  wire logic           finish,
    output logic                start,
    output logic                program_clk_en,
    output logic                program_reset,

    input  wire logic           main_enable_a,
    input  wire logic           main_enable_b,
    input  wire logic           main_write_enable_a,
    input  wire logic           main_write_enable_b,
    input  wire mem_pkg::addr_t main_address_a,
    input  wire mem_pkg::addr_t main_address_b,
    input  wire mem_pkg::data_t main_in_a,
    input  wire mem_pkg::data_t main_in_b,
    input  wire mem_pkg::size_t main_size_a,
    input  wire mem_pkg::size_t main_size_b,
    output mem_pkg::data_t      main_out_a,
    output mem_pkg::data_t      main_out_b,

    output logic                memory_controller_enable_a,
    output logic                memory_controller_enable_b,
    output logic                memory_controller_write_enable_a,
    output logic                memory_controller_write_enable_b,
    output mem_pkg::addr_t      memory_controller_address_a,
    output mem_pkg::addr_t      memory_controller_address_b,
    output mem_pkg::data_t      memory_controller_in_a,
    output mem_pkg::data_t      memory_controller_in_b,
    output mem_pkg::size_t      memory_controller_size_a,
    output mem_pkg::size_t      memory_controller_size_b,
    input  wire mem_pkg::data_t memory_controller_out_a,
    input  wire mem_pkg::data_t memory_controller_out_b,

    input  wire logic           dbg_rd_en,
    input  wire logic           dbg_wr_en,
    input  wire mem_pkg::addr_t dbg_addr,
    input  wire mem_pkg::data_t dbg_writedata,
    output mem_pkg::data_t      dbg_readdata,
    output logic                dbg_waitrequest
);

    logic                  running;
    debug_pkg::sup_state_t sup_state;

    mem_port_if prog_a ();
    mem_port_if prog_b ();
    mem_port_if ctrl_a ();
    mem_port_if ctrl_b ();

    // Program side
    assign prog_a.enable       = main_enable_a;
    assign prog_a.write_enable = main_write_enable_a;
    assign prog_a.address      = main_address_a;
    assign prog_a.wr_data      = main_in_a;
    assign prog_a.size         = main_size_a;
    assign prog_a.rd_data      = main_out_a;
    assign prog_b.enable       = main_enable_b;
    assign prog_b.write_enable = main_write_enable_b;
    assign prog_b.address      = main_address_b;
    assign prog_b.wr_data      = main_in_b;
    assign prog_b.size         = main_size_b;
    assign prog_b.rd_data      = main_out_b;

    // Memory controller side
    assign memory_controller_enable_a       = ctrl_a.enable;
    assign memory_controller_write_enable_a = ctrl_a.write_enable;
    assign memory_controller_address_a      = ctrl_a.address;
    assign memory_controller_in_a           = ctrl_a.wr_data;
    assign memory_controller_size_a         = ctrl_a.size;
    assign ctrl_a.rd_data                   = memory_controller_out_a;
    assign memory_controller_enable_b       = ctrl_b.enable;
    assign memory_controller_write_enable_b = ctrl_b.write_enable;
    assign memory_controller_address_b      = ctrl_b.address;
    assign memory_controller_in_b           = ctrl_b.wr_data;
    assign memory_controller_size_b         = ctrl_b.size;
    assign ctrl_b.rd_data                   = memory_controller_out_b;

    run_control i_run_control (
        .clk            (clk),
        .reset          (reset),
        .run_req        (run_req),
        .reset_req      (reset_req),
        .finish         (finish),
        .running        (running),
        .program_reset  (program_reset),
        .program_clk_en (program_clk_en),
        .start          (start)
    );

    supervisor_fsm #(
        .replay_on_resume (replay_on_resume)
    ) i_supervisor_fsm (
        .clk             (clk),
        .reset           (program_reset),
        .running         (running),
        .prog_a          (prog_a.responder),
        .prog_b          (prog_b.responder),
        .ctrl_a          (ctrl_a.requester),
        .ctrl_b          (ctrl_b.requester),
        .dbg_rd_en       (dbg_rd_en),
        .dbg_wr_en       (dbg_wr_en),
        .dbg_addr        (dbg_addr),
        .dbg_writedata   (dbg_writedata),
        .dbg_readdata    (dbg_readdata),
        .dbg_waitrequest (dbg_waitrequest),
        .state           (sup_state)
    );

    read_replay #(
        .replay_on_resume (replay_on_resume)
    ) i_read_replay (
        .clk        (clk),
        .running    (running),
        .state      (sup_state),
        .ctrl_rd_a  (ctrl_a.rd_data),
        .ctrl_rd_b  (ctrl_b.rd_data),
        .main_out_a (main_out_a),
        .main_out_b (main_out_b)
    );

endmodule

`default_nettype wire

// ==== hw/read_replay.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_replay #(
    parameter bit replay_on_resume = 1'b1
) (
    input  wire logic                  clk,
    input  wire logic                  running,
    input  wire debug_pkg::sup_state_t state,
    input  wire mem_pkg::data_t        ctrl_rd_a,
    input  wire mem_pkg::data_t        ctrl_rd_b,
    output mem_pkg::data_t             main_out_a,
    output mem_pkg::data_t             main_out_b
);

    generate
        if (replay_on_resume) begin : g_replay
            logic           running_d1;
            logic           running_d2;
            mem_pkg::data_t hist_old_a;
            mem_pkg::data_t hist_new_a;
            mem_pkg::data_t hist_old_b;
            mem_pkg::data_t hist_new_b;

            always_ff @(posedge clk) begin
                running_d1 <= running;
                running_d2 <= running_d1;
            end

            // Read data lags the request, so the history keeps filling two cycles after a stop
            always_ff @(posedge clk) begin
                if (running_d2) begin
                    hist_new_a <= ctrl_rd_a;
                    hist_old_a <= hist_new_a;
                    hist_new_b <= ctrl_rd_b;
                    hist_old_b <= hist_new_b;
                end
            end

            always_comb begin
                if (state == debug_pkg::sup_stopped && running) begin
                    main_out_a = hist_old_a;
                    main_out_b = hist_old_b;
                end else if (state == debug_pkg::sup_starting) begin
                    main_out_a = hist_new_a;
                    main_out_b = hist_new_b;
                end else begin
                    main_out_a = ctrl_rd_a;
                    main_out_b = ctrl_rd_b;
                end
            end
        end else begin : g_live
            assign main_out_a = ctrl_rd_a;
            assign main_out_b = ctrl_rd_b;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hw/supervisor_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module supervisor_fsm #(
    parameter bit replay_on_resume = 1'b1
) (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            running,
    mem_port_if.responder        prog_a,
    mem_port_if.responder        prog_b,
    mem_port_if.requester        ctrl_a,
    mem_port_if.requester        ctrl_b,
    input  wire logic            dbg_rd_en,
    input  wire logic            dbg_wr_en,
    input  wire mem_pkg::addr_t  dbg_addr,
    input  wire mem_pkg::data_t  dbg_writedata,
    output mem_pkg::data_t       dbg_readdata,
    output logic                 dbg_waitrequest,
    output debug_pkg::sup_state_t state
);

    // Debug accesses always move a full word
    localparam mem_pkg::size_t dbg_size = 2'd3;

    logic dbg_req;
    logic dbg_done;

    assign dbg_req = dbg_rd_en | dbg_wr_en;
    assign dbg_done = (state == debug_pkg::sup_read_done) ||
                      (state == debug_pkg::sup_write_done);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= debug_pkg::sup_stopped;
        end else begin
            case (state)
                debug_pkg::sup_stopped: begin
                    if (running) begin
                        if (replay_on_resume) begin
                            state <= debug_pkg::sup_starting;
                        end else begin
                            state <= debug_pkg::sup_running;
                        end
                    end else if (dbg_rd_en) begin
                        state <= debug_pkg::sup_read_request;
                    end else if (dbg_wr_en) begin
                        state <= debug_pkg::sup_write_request;
                    end
                end
                debug_pkg::sup_starting: begin
                    state <= debug_pkg::sup_running;
                end
                debug_pkg::sup_running: begin
                    if (!running) begin
                        state <= debug_pkg::sup_stopped;
                    end
                end
                // Read data arrives one cycle after the request and is sampled a cycle later
                debug_pkg::sup_read_request: begin
                    state <= debug_pkg::sup_read_stall;
                end
                debug_pkg::sup_read_stall: begin
                    state <= debug_pkg::sup_read_done;
                end
                debug_pkg::sup_write_request: begin
                    state <= debug_pkg::sup_write_done;
                end
                default: begin
                    state <= debug_pkg::sup_stopped;
                end
            endcase
        end
    end

    always_comb begin
        ctrl_a.enable       = 1'b0;
        ctrl_a.write_enable = 1'b0;
        ctrl_a.address      = dbg_addr;
        ctrl_a.wr_data      = dbg_writedata;
        ctrl_a.size         = dbg_size;
        ctrl_b.enable       = 1'b0;
        ctrl_b.write_enable = 1'b0;
        ctrl_b.address      = '0;
        ctrl_b.wr_data      = '0;
        ctrl_b.size         = '0;
        dbg_readdata        = ctrl_a.rd_data;
        dbg_waitrequest     = dbg_req & ~dbg_done;

        if (running) begin
            // Program owns both ports
            ctrl_a.enable       = prog_a.enable;
            ctrl_a.write_enable = prog_a.write_enable;
            ctrl_a.address      = prog_a.address;
            ctrl_a.wr_data      = prog_a.wr_data;
            ctrl_a.size         = prog_a.size;
            ctrl_b.enable       = prog_b.enable;
            ctrl_b.write_enable = prog_b.write_enable;
            ctrl_b.address      = prog_b.address;
            ctrl_b.wr_data      = prog_b.wr_data;
            ctrl_b.size         = prog_b.size;
            dbg_readdata        = '0;
            dbg_waitrequest     = dbg_req;
        end else begin
            case (state)
                debug_pkg::sup_read_request: begin
                    ctrl_a.enable = 1'b1;
                end
                debug_pkg::sup_write_request: begin
                    ctrl_a.enable       = 1'b1;
                    ctrl_a.write_enable = 1'b1;
                end
                default: begin
                    ctrl_a.enable = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/run_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module run_control (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic run_req,
    input  wire logic reset_req,
    input  wire logic finish,
    output logic      running,
    output logic      program_reset,
    output logic      program_clk_en,
    output logic      start
);

    debug_pkg::seq_state_t seq_state;

    assign running = run_req;
    assign program_reset = reset | reset_req;

    // The program resets synchronously, so it must be clocked during reset
    assign program_clk_en = running | program_reset;

    always_ff @(posedge clk or posedge program_reset) begin
        if (program_reset) begin
            seq_state <= debug_pkg::seq_idle;
        end else if (program_clk_en) begin
            case (seq_state)
                debug_pkg::seq_idle: begin
                    seq_state <= debug_pkg::seq_start;
                end
                debug_pkg::seq_start: begin
                    seq_state <= debug_pkg::seq_wait;
                end
                debug_pkg::seq_wait: begin
                    if (finish) begin
                        seq_state <= debug_pkg::seq_finished;
                    end
                end
                default: begin
                    seq_state <= seq_state;
                end
            endcase
        end
    end

    assign start = (seq_state == debug_pkg::seq_start);

endmodule

`default_nettype wire

// ==== hw/mem_port_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mem_port_if;

    logic           enable;
    mem_pkg::addr_t address;
    logic           write_enable;
    mem_pkg::data_t wr_data;
    mem_pkg::size_t size;
    mem_pkg::data_t rd_data;

    // Side that issues accesses
    modport requester (
        output enable,
        output address,
        output write_enable,
        output wr_data,
        output size,
        input  rd_data
    );

    // Side that serves accesses and returns read data
    modport responder (
        input  enable,
        input  address,
        input  write_enable,
        input  wr_data,
        input  size,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== hw/debug_pkg.sv ====
`default_nettype none

package debug_pkg;

    // Memory ownership between the program and the debug port
    typedef enum logic [3:0] {
        sup_stopped,
        sup_starting,
        sup_running,
        sup_read_request,
        sup_read_stall,
        sup_read_done,
        sup_write_request,
        sup_write_done
    } sup_state_t;

    // Start pulse and finish tracking for the program
    typedef enum logic [1:0] {
        seq_idle,
        seq_start,
        seq_wait,
        seq_finished
    } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Memory controller bus widths
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 64;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;

    // Access size code where 3 selects a full 64-bit word
    typedef logic [1:0] size_t;

endpackage

`default_nettype wire
